//--- Bender.yml
package:
  name: soc_ctrl

sources:
  - common/soc_ctrl_pkg.sv
  - design/apb_reg_port.sv
  - pad_ctrl/pad_ctrl_regs.sv
  - design/boot_cluster_regs.sv
  - design/soc_status_regs.sv
  - design/soc_ctrl_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_soc_ctrl.sv

//--- common/soc_ctrl_pkg.sv
/*
 Shared widths, word addresses and reset values of the SoC control block.
 Word addresses are PADDR[8:2]. Pad config fields sit in byte slots.
*/
`default_nettype none

package soc_ctrl_pkg;

   localparam int APB_ADDR_W = 12;
   localparam int REG_ADDR_W = 7;             // PADDR[8:2]
   localparam int WORD_W     = 32;

   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [WORD_W-1:0]     word_t;

   localparam int NUM_PADS     = 64;
   localparam int PAD_FUN_W    = 2;
   localparam int PAD_CFG_W    = 6;           // pu, pd, st, slew, drive[1:0]
   localparam int CFG_SLOT_W   = 8;
   localparam int PADS_PER_FUN = WORD_W / PAD_FUN_W;
   localparam int PADS_PER_CFG = WORD_W / CFG_SLOT_W;
   localparam int PADFUN_WORDS = NUM_PADS / PADS_PER_FUN;
   localparam int PADCFG_WORDS = NUM_PADS / PADS_PER_CFG;

   typedef logic [PAD_FUN_W-1:0] pad_fun_t;
   typedef logic [PAD_CFG_W-1:0] pad_cfg_t;

   localparam int JTAG_REG_W = 8;
   typedef logic [JTAG_REG_W-1:0] jtag_reg_t;

   localparam int NB_CORES    = 4;
   localparam int NB_CLUSTERS = 1;

   localparam reg_addr_t ADDR_INFO          = 7'h00;
   localparam reg_addr_t ADDR_FCBOOT        = 7'h01;
   localparam reg_addr_t ADDR_FCFETCH       = 7'h02;
   localparam reg_addr_t ADDR_PADFUN_BASE   = 7'h04; // four words
   localparam reg_addr_t ADDR_PADCFG_BASE   = 7'h08; // sixteen words
   localparam reg_addr_t ADDR_CLUSTER_CTRL  = 7'h1C;
   localparam reg_addr_t ADDR_JTAGREG       = 7'h1D;
   localparam reg_addr_t ADDR_CLUSTER_IRQ   = 7'h1F;
   localparam reg_addr_t ADDR_CLUSTER_BOOT0 = 7'h20;
   localparam reg_addr_t ADDR_CLUSTER_BOOT1 = 7'h21;
   localparam reg_addr_t ADDR_CORESTATUS    = 7'h28;
   localparam reg_addr_t ADDR_CS_RO         = 7'h30;
   localparam reg_addr_t ADDR_BOOTSEL       = 7'h31;
   localparam reg_addr_t ADDR_CLKSEL        = 7'h32;

   localparam word_t FC_BOOT_RESET = 32'h1A00_0080;

   typedef struct packed {
      logic      wr;                          // access phase write strobe
      reg_addr_t addr;
      word_t     wdata;
   } reg_req_t;

   typedef struct packed {
      logic rstn;
      logic fetch_en;
      logic pow;
      logic byp;                              // bit 0
   } cluster_ctrl_t;

endpackage

`default_nettype wire

//--- design/apb_reg_port.sv
/*
 APB slave front end, zero wait states, no error response.
 Register blocks must return zero read data when they do not hit.
*/
`timescale 1ns/10ps
`default_nettype none

module apb_reg_port
   import soc_ctrl_pkg::*;
(
   input  wire logic                  HCLK,
   input  wire logic                  HRESETn,
   input  wire logic [APB_ADDR_W-1:0] paddr_i,
   input  wire word_t                 pwdata_i,
   input  wire logic                  pwrite_i,
   input  wire logic                  psel_i,
   input  wire logic                  penable_i,
   output word_t                      prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o,
   output reg_req_t                   req_o,
   input  wire word_t                 pad_rdata_i,
   input  wire word_t                 boot_rdata_i,
   input  wire word_t                 stat_rdata_i,
   input  wire logic                  pad_hit_i,
   input  wire logic                  boot_hit_i,
   input  wire logic                  stat_hit_i
);

   assign req_o.wr    = psel_i & penable_i & pwrite_i;
   assign req_o.addr  = paddr_i[REG_ADDR_W+1:2];    // word address
   assign req_o.wdata = pwdata_i;

   always_comb
   begin
      prdata_o = '0;
      if (pad_hit_i)
         prdata_o = pad_rdata_i;
      else if (boot_hit_i)
         prdata_o = boot_rdata_i;
      else if (stat_hit_i)
         prdata_o = stat_rdata_i;
   end

   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   // the address map must not overlap between blocks
   a_single_hit : assert property (@(posedge HCLK) disable iff (!HRESETn)
      $onehot0({pad_hit_i, boot_hit_i, stat_hit_i}));

   a_apb_setup : assert property (@(posedge HCLK) disable iff (!HRESETn)
      $rose(penable_i) |-> $past(psel_i));   // access follows a setup cycle

endmodule

`default_nettype wire

//--- design/boot_cluster_regs.sv
/*
 Fabric controller boot/fetch and cluster control registers.
 FCFETCH is write-only and reads zero. An APB write to FCFETCH overrides
 the fetch enable load from the valid/data pair in the same cycle.
*/
`timescale 1ns/10ps
`default_nettype none

module boot_cluster_regs
   import soc_ctrl_pkg::*;
(
   input  wire logic         HCLK,
   input  wire logic         HRESETn,
   input  wire reg_req_t     req_i,
   input  wire logic         fc_fetch_en_valid_i,
   input  wire logic         fc_fetch_en_i,
   output word_t             rdata_o,
   output logic              hit_o,
   output word_t             fc_bootaddr_o,
   output logic              fc_fetchen_o,
   output cluster_ctrl_t     cluster_ctrl_o,
   output logic [63:0]       cluster_boot_addr_o,
   output logic              cluster_irq_o
);

   word_t          r_bootaddr;
   logic           r_fetchen;
   cluster_ctrl_t  r_cluster_ctrl;
   logic [63:0]    r_cluster_boot;
   logic           r_cluster_irq;
   logic           fetch_wr;

   assign fetch_wr = req_i.wr && (req_i.addr == ADDR_FCFETCH);

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_bootaddr     <= FC_BOOT_RESET;
         r_fetchen      <= 1'b0;             // fc idle until enabled
         r_cluster_ctrl <= '{rstn: 1'b1, fetch_en: 1'b0, pow: 1'b0, byp: 1'b1};
         r_cluster_boot <= '0;
         r_cluster_irq  <= 1'b0;
      end
      else
      begin
         if (fc_fetch_en_valid_i)
            r_fetchen <= fc_fetch_en_i;
         if (fetch_wr)
            r_fetchen <= req_i.wdata[0];     // apb has priority
         if (req_i.wr)
         begin
            case (req_i.addr)
               ADDR_FCBOOT:        r_bootaddr           <= req_i.wdata;
               ADDR_CLUSTER_CTRL:  r_cluster_ctrl       <= req_i.wdata[3:0];
               ADDR_CLUSTER_IRQ:   r_cluster_irq        <= req_i.wdata[0];
               ADDR_CLUSTER_BOOT0: r_cluster_boot[31:0]  <= req_i.wdata;
               ADDR_CLUSTER_BOOT1: r_cluster_boot[63:32] <= req_i.wdata;
               default: ;
            endcase
         end
      end
   end

   always_comb
   begin
      rdata_o = '0;
      hit_o   = 1'b1;
      case (req_i.addr)
         ADDR_FCBOOT:        rdata_o = r_bootaddr;
         ADDR_FCFETCH:       rdata_o = '0;   // write only
         ADDR_CLUSTER_CTRL:  rdata_o = {28'h0, r_cluster_ctrl};
         ADDR_CLUSTER_IRQ:   rdata_o = {31'h0, r_cluster_irq};
         ADDR_CLUSTER_BOOT0: rdata_o = r_cluster_boot[31:0];
         ADDR_CLUSTER_BOOT1: rdata_o = r_cluster_boot[63:32];
         default:            hit_o   = 1'b0;
      endcase
   end

   assign fc_bootaddr_o       = r_bootaddr;
   assign fc_fetchen_o        = r_fetchen;
   assign cluster_ctrl_o      = r_cluster_ctrl;
   assign cluster_boot_addr_o = r_cluster_boot;
   assign cluster_irq_o       = r_cluster_irq;

   // side-band fetch enable lands one edge later unless apb overrides it
   a_fetch_load : assert property (@(posedge HCLK) disable iff (!HRESETn)
      fc_fetch_en_valid_i && !fetch_wr |=> fc_fetchen_o == $past(fc_fetch_en_i));

endmodule

`default_nettype wire

//--- design/soc_ctrl_top.sv
/*
 SoC control register block on APB, zero wait states, PSLVERR always low.
 Unmapped word addresses read zero and ignore writes.
*/
`timescale 1ns/10ps
`default_nettype none

module soc_ctrl_top
   import soc_ctrl_pkg::*;
(
   input  wire logic                  HCLK,
   input  wire logic                  HRESETn,
   input  wire logic [APB_ADDR_W-1:0] PADDR,
   input  wire word_t                 PWDATA,
   input  wire logic                  PWRITE,
   input  wire logic                  PSEL,
   input  wire logic                  PENABLE,
   output word_t                      PRDATA,
   output logic                       PREADY,
   output logic                       PSLVERR,
   output pad_fun_t [NUM_PADS-1:0]    pad_mux_o,
   output pad_cfg_t [NUM_PADS-1:0]    pad_cfg_o,
   input  wire logic                  fc_fetch_en_valid_i,
   input  wire logic                  fc_fetch_en_i,
   output word_t                      fc_bootaddr_o,
   output logic                       fc_fetchen_o,
   output cluster_ctrl_t              cluster_ctrl_o,
   output logic [63:0]                cluster_boot_addr_o,
   output logic                       cluster_irq_o,
   input  wire jtag_reg_t             soc_jtag_reg_i,
   input  wire logic                  bootsel_i,
   input  wire logic                  sel_fll_clk_i,
   output jtag_reg_t                  soc_jtag_reg_o
);

   reg_req_t req;
   word_t    pad_rdata;
   word_t    boot_rdata;
   word_t    stat_rdata;
   logic     pad_hit;
   logic     boot_hit;
   logic     stat_hit;

   apb_reg_port u_apb_port (
      .HCLK         (HCLK),
      .HRESETn      (HRESETn),
      .paddr_i      (PADDR),
      .pwdata_i     (PWDATA),
      .pwrite_i     (PWRITE),
      .psel_i       (PSEL),
      .penable_i    (PENABLE),
      .prdata_o     (PRDATA),
      .pready_o     (PREADY),
      .pslverr_o    (PSLVERR),
      .req_o        (req),
      .pad_rdata_i  (pad_rdata),
      .boot_rdata_i (boot_rdata),
      .stat_rdata_i (stat_rdata),
      .pad_hit_i    (pad_hit),
      .boot_hit_i   (boot_hit),
      .stat_hit_i   (stat_hit)
   );

   pad_ctrl_regs u_pad_regs (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .req_i     (req),
      .rdata_o   (pad_rdata),
      .hit_o     (pad_hit),
      .pad_mux_o (pad_mux_o),
      .pad_cfg_o (pad_cfg_o)
   );

   boot_cluster_regs u_boot_regs (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .req_i               (req),
      .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
      .fc_fetch_en_i       (fc_fetch_en_i),
      .rdata_o             (boot_rdata),
      .hit_o               (boot_hit),
      .fc_bootaddr_o       (fc_bootaddr_o),
      .fc_fetchen_o        (fc_fetchen_o),
      .cluster_ctrl_o      (cluster_ctrl_o),
      .cluster_boot_addr_o (cluster_boot_addr_o),
      .cluster_irq_o       (cluster_irq_o)
   );

   soc_status_regs u_stat_regs (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .req_i          (req),
      .soc_jtag_reg_i (soc_jtag_reg_i),
      .bootsel_i      (bootsel_i),
      .sel_fll_clk_i  (sel_fll_clk_i),
      .rdata_o        (stat_rdata),
      .hit_o          (stat_hit),
      .soc_jtag_reg_o (soc_jtag_reg_o)
   );

endmodule

`default_nettype wire

//--- design/soc_status_regs.sv
/*
 Info, core status, JTAG exchange, boot select and clock select registers.
 JTAG input and boot select pass two flops before readback.
 Clock select is read raw.
*/
`timescale 1ns/10ps
`default_nettype none

module soc_status_regs
   import soc_ctrl_pkg::*;
(
   input  wire logic       HCLK,
   input  wire logic       HRESETn,
   input  wire reg_req_t   req_i,
   input  wire jtag_reg_t  soc_jtag_reg_i,
   input  wire logic       bootsel_i,
   input  wire logic       sel_fll_clk_i,
   output word_t           rdata_o,
   output logic            hit_o,
   output jtag_reg_t       soc_jtag_reg_o
);

   jtag_reg_t    r_jtag_meta;
   jtag_reg_t    r_jtag_sync;
   jtag_reg_t    r_jtag_rego;
   word_t        r_corestatus;
   logic [1:0]   r_bootsel;

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_jtag_meta  <= '0;
         r_jtag_sync  <= '0;
         r_jtag_rego  <= '0;
         r_corestatus <= '0;
         r_bootsel    <= '0;
      end
      else
      begin
         r_jtag_meta <= soc_jtag_reg_i;
         r_jtag_sync <= r_jtag_meta;
         r_bootsel   <= {r_bootsel[0], bootsel_i}; // shift history
         if (req_i.wr && req_i.addr == ADDR_JTAGREG)
            r_jtag_rego <= req_i.wdata[JTAG_REG_W-1:0];
         if (req_i.wr && req_i.addr == ADDR_CORESTATUS)
            r_corestatus <= req_i.wdata;     // eoc in bit 31
      end
   end

   always_comb
   begin
      rdata_o = '0;
      hit_o   = 1'b1;
      case (req_i.addr)
         ADDR_INFO:       rdata_o = {16'(NB_CORES), 16'(NB_CLUSTERS)};
         ADDR_JTAGREG:    rdata_o = {16'h0, r_jtag_sync, r_jtag_rego};
         ADDR_CORESTATUS: rdata_o = r_corestatus;
         ADDR_CS_RO:      rdata_o = r_corestatus; // read-only mirror
         ADDR_BOOTSEL:    rdata_o = {30'h0, r_bootsel};
         ADDR_CLKSEL:     rdata_o = {31'h0, sel_fll_clk_i};
         default:         hit_o   = 1'b0;
      endcase
   end

   assign soc_jtag_reg_o = r_jtag_rego;

endmodule

`default_nettype wire

//--- files.f
+incdir+test
common/soc_ctrl_pkg.sv
design/apb_reg_port.sv
pad_ctrl/pad_ctrl_regs.sv
design/boot_cluster_regs.sv
design/soc_status_regs.sv
design/soc_ctrl_top.sv
test/tb_soc_ctrl.sv

//--- pad_ctrl/pad_ctrl_regs.sv
/*
 Pad function and pad configuration registers.
 Function words pack 16 pads of 2 bits, config words 4 pads per byte slot.
 Unused config slot bits read as zero.
*/
`timescale 1ns/10ps
`default_nettype none

module pad_ctrl_regs
   import soc_ctrl_pkg::*;
(
   input  wire logic                      HCLK,
   input  wire logic                      HRESETn,
   input  wire reg_req_t                  req_i,
   output word_t                          rdata_o,
   output logic                           hit_o,
   output pad_fun_t [NUM_PADS-1:0]        pad_mux_o,
   output pad_cfg_t [NUM_PADS-1:0]        pad_cfg_o
);

   localparam int FUN_IDX_W = $clog2(PADFUN_WORDS);
   localparam int CFG_IDX_W = $clog2(PADCFG_WORDS);

   pad_fun_t [NUM_PADS-1:0] r_pad_fun;
   pad_cfg_t [NUM_PADS-1:0] r_pad_cfg;

   reg_addr_t              fun_off;
   reg_addr_t              cfg_off;
   logic [FUN_IDX_W-1:0]   fun_idx;
   logic [CFG_IDX_W-1:0]   cfg_idx;
   logic                   fun_hit;
   logic                   cfg_hit;

   assign fun_off = req_i.addr - ADDR_PADFUN_BASE;
   assign cfg_off = req_i.addr - ADDR_PADCFG_BASE;
   assign fun_idx = fun_off[FUN_IDX_W-1:0];
   assign cfg_idx = cfg_off[CFG_IDX_W-1:0];

   assign fun_hit = (req_i.addr >= ADDR_PADFUN_BASE) &&
                    (req_i.addr < ADDR_PADFUN_BASE + PADFUN_WORDS);
   assign cfg_hit = (req_i.addr >= ADDR_PADCFG_BASE) &&
                    (req_i.addr < ADDR_PADCFG_BASE + PADCFG_WORDS);
   assign hit_o   = fun_hit | cfg_hit;

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_pad_fun <= '0;
         r_pad_cfg <= '1;                     // pull up, pull down, max drive
      end
      else if (req_i.wr)
      begin
         if (fun_hit)
         begin
            for (int i = 0; i < PADS_PER_FUN; i++)
            begin
               r_pad_fun[fun_idx*PADS_PER_FUN + i] <= req_i.wdata[i*PAD_FUN_W +: PAD_FUN_W];
            end
         end
         if (cfg_hit)
         begin
            for (int i = 0; i < PADS_PER_CFG; i++)
            begin
               r_pad_cfg[cfg_idx*PADS_PER_CFG + i] <= req_i.wdata[i*CFG_SLOT_W +: PAD_CFG_W];
            end
         end
      end
   end

   always_comb
   begin
      rdata_o = '0;
      if (fun_hit)
      begin
         for (int i = 0; i < PADS_PER_FUN; i++)
         begin
            rdata_o[i*PAD_FUN_W +: PAD_FUN_W] = r_pad_fun[fun_idx*PADS_PER_FUN + i];
         end
      end
      else if (cfg_hit)
      begin
         for (int i = 0; i < PADS_PER_CFG; i++)
         begin
            rdata_o[i*CFG_SLOT_W +: PAD_CFG_W] = r_pad_cfg[cfg_idx*PADS_PER_CFG + i];
         end
      end
   end

   assign pad_mux_o = r_pad_fun;
   assign pad_cfg_o = r_pad_cfg;

   a_pad_stable : assert property (@(posedge HCLK) disable iff (!HRESETn)
      !(req_i.wr && hit_o) |=> $stable(r_pad_fun) && $stable(r_pad_cfg));

endmodule

`default_nettype wire

//--- test/tb_soc_ctrl_seq.svh
/*
 APB access task and the stimulus table, built at run time from $urandom.
 Include inside tb_soc_ctrl after its signal declarations.
 Read rows are compared under their mask, write rows ignore exp and mask.
*/
`ifndef TB_SOC_CTRL_SEQ_SVH
`define TB_SOC_CTRL_SEQ_SVH

typedef struct packed {
   logic      wr;
   reg_addr_t addr;
   word_t     wdata;
   word_t     exp;
   word_t     mask;
} step_t;

string     step_name[$];
step_t     steps[$];
word_t     fun_words [4];
word_t     cfg_words [16];
word_t     fcboot_w;
word_t     boot0_w;
word_t     boot1_w;
word_t     cctrl_w;
word_t     irq_w;
word_t     cstat_w;
word_t     jtag_w;
jtag_reg_t jtag_in;

task automatic add_step(input string name, input logic wr, input reg_addr_t addr,
                        input word_t wdata, input word_t exp, input word_t mask);
   step_t s;
   s.wr    = wr;
   s.addr  = addr;
   s.wdata = wdata;
   s.exp   = exp;
   s.mask  = mask;
   step_name.push_back(name);
   steps.push_back(s);
endtask

task automatic write_row(input string name, input reg_addr_t addr, input word_t wdata);
   add_step(name, 1'b1, addr, wdata, '0, '0);
endtask

task automatic read_row(input string name, input reg_addr_t addr, input word_t exp,
                        input word_t mask);
   add_step(name, 1'b0, addr, '0, exp, mask);
endtask

// one setup cycle, one access cycle, read data sampled mid access cycle
task automatic apb_access(input logic wr, input reg_addr_t addr, input word_t wdata,
                          output word_t rdata);
   @(negedge HCLK);
   PSEL    = 1'b1;
   PENABLE = 1'b0;
   PWRITE  = wr;
   PADDR   = {3'b000, addr, 2'b00};
   PWDATA  = wdata;
   @(negedge HCLK);
   PENABLE = 1'b1;
   #1;
   rdata = PRDATA;
   check_value("pready", 1, PREADY);
   check_value("pslverr", 0, PSLVERR);
endtask

task automatic bus_idle();
   @(negedge HCLK);
   PSEL    = 1'b0;
   PENABLE = 1'b0;
   PWRITE  = 1'b0;
endtask

task automatic build_table();
   fcboot_w = $urandom;
   boot0_w  = $urandom;
   boot1_w  = $urandom;
   cctrl_w  = $urandom;
   irq_w    = $urandom;
   cstat_w  = $urandom;
   jtag_w   = $urandom;
   read_row("reset_fcboot", ADDR_FCBOOT, 32'h1A00_0080, '1);
   read_row("reset_cluster_ctrl", ADDR_CLUSTER_CTRL, 32'h9, '1); // rstn bit 3, byp bit 0
   read_row("reset_info", ADDR_INFO, 32'h0004_0001, '1);
   for (int i = 0; i < 4; i++)
   begin
      read_row($sformatf("reset_padfun%0d", i), reg_addr_t'(ADDR_PADFUN_BASE + i), '0, '1);
   end
   for (int i = 0; i < 16; i++)
   begin
      read_row($sformatf("reset_padcfg%0d", i), reg_addr_t'(ADDR_PADCFG_BASE + i),
               32'h3F3F_3F3F, '1);
   end
   for (int i = 0; i < 4; i++)
   begin
      fun_words[i] = $urandom;
      write_row($sformatf("wr_padfun%0d", i), reg_addr_t'(ADDR_PADFUN_BASE + i), fun_words[i]);
      read_row($sformatf("padfun%0d", i), reg_addr_t'(ADDR_PADFUN_BASE + i), fun_words[i], '1);
   end
   for (int i = 0; i < 16; i++)
   begin
      cfg_words[i] = $urandom;
      write_row($sformatf("wr_padcfg%0d", i), reg_addr_t'(ADDR_PADCFG_BASE + i), cfg_words[i]);
      read_row($sformatf("padcfg%0d", i), reg_addr_t'(ADDR_PADCFG_BASE + i), cfg_words[i],
               32'h3F3F_3F3F);                       // six-bit fields only
   end
   write_row("wr_fcboot", ADDR_FCBOOT, fcboot_w);
   write_row("wr_boot0", ADDR_CLUSTER_BOOT0, boot0_w);
   write_row("wr_boot1", ADDR_CLUSTER_BOOT1, boot1_w);
   write_row("wr_cluster_ctrl", ADDR_CLUSTER_CTRL, cctrl_w);
   write_row("wr_cluster_irq", ADDR_CLUSTER_IRQ, irq_w);
   read_row("fcboot", ADDR_FCBOOT, fcboot_w, '1);
   read_row("boot0", ADDR_CLUSTER_BOOT0, boot0_w, '1);
   read_row("boot1", ADDR_CLUSTER_BOOT1, boot1_w, '1);
   read_row("cluster_ctrl", ADDR_CLUSTER_CTRL, cctrl_w, 32'hF);
   read_row("cluster_irq", ADDR_CLUSTER_IRQ, irq_w, 32'h1);
   read_row("fcfetch_wo", ADDR_FCFETCH, '0, '1);       // write only, reads zero
   write_row("wr_corestatus", ADDR_CORESTATUS, cstat_w);
   read_row("corestatus", ADDR_CORESTATUS, cstat_w, '1);
   read_row("cs_ro", ADDR_CS_RO, cstat_w, '1);
   write_row("wr_cs_ro", ADDR_CS_RO, ~cstat_w);
   read_row("corestatus_kept", ADDR_CORESTATUS, cstat_w, '1);
   read_row("cs_ro_kept", ADDR_CS_RO, cstat_w, '1);
   write_row("wr_jtagreg", ADDR_JTAGREG, jtag_w);
   read_row("jtagreg", ADDR_JTAGREG, {16'h0, jtag_in, jtag_w[7:0]}, '1);
   read_row("bootsel", ADDR_BOOTSEL, 32'h3, '1);
   read_row("clksel", ADDR_CLKSEL, 32'h1, '1);
   write_row("wr_unmapped", 7'h03, $urandom);
   read_row("unmapped", 7'h03, '0, '1);
   read_row("fcboot_after_unmapped", ADDR_FCBOOT, fcboot_w, '1);
   read_row("padfun0_after_unmapped", ADDR_PADFUN_BASE, fun_words[0], '1);
endtask

`endif

//--- test/tb_soc_ctrl.sv
/*
 Testbench for soc_ctrl_top. APB rows come from the table in the header.
 Inputs change on the falling edge, the first mismatch ends the run.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_soc_ctrl;
   import soc_ctrl_pkg::*;

   localparam int RESET_CYCLES = 16;

   logic                    HCLK = 1'b0;
   logic                    HRESETn;
   logic [APB_ADDR_W-1:0]   PADDR;
   word_t                   PWDATA;
   logic                    PWRITE;
   logic                    PSEL;
   logic                    PENABLE;
   word_t                   PRDATA;
   logic                    PREADY;
   logic                    PSLVERR;
   pad_fun_t [NUM_PADS-1:0] pad_mux_o;
   pad_cfg_t [NUM_PADS-1:0] pad_cfg_o;
   logic                    fc_fetch_en_valid_i;
   logic                    fc_fetch_en_i;
   word_t                   fc_bootaddr_o;
   logic                    fc_fetchen_o;
   cluster_ctrl_t           cluster_ctrl_o;
   logic [63:0]             cluster_boot_addr_o;
   logic                    cluster_irq_o;
   jtag_reg_t               soc_jtag_reg_i;
   logic                    bootsel_i;
   logic                    sel_fll_clk_i;
   jtag_reg_t               soc_jtag_reg_o;
   int                      cycle_count = 0;
   int                      cycle_limit = 0;
   int                      sample_pads [4] = '{0, 17, 38, 63};

   soc_ctrl_top dut0 (.*);

   always #20 HCLK = ~HCLK;

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      if (exp !== act)
      begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         $display("SIMULATION FAILED");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   `include "tb_soc_ctrl_seq.svh"

   always @(posedge HCLK)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("SIMULATION FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic check_reset_ports();
      check_value("rst_fc_fetchen", 0, fc_fetchen_o);
      check_value("rst_fc_bootaddr", 32'h1A00_0080, fc_bootaddr_o);
      check_value("rst_cluster_byp", 1, cluster_ctrl_o.byp);
      check_value("rst_cluster_rstn", 1, cluster_ctrl_o.rstn);
      check_value("rst_cluster_pow", 0, cluster_ctrl_o.pow);
      check_value("rst_cluster_fetch_en", 0, cluster_ctrl_o.fetch_en);
      check_value("rst_cluster_irq", 0, cluster_irq_o);
      check_value("rst_cluster_boot", 0, cluster_boot_addr_o);
      check_value("rst_jtag_out", 0, soc_jtag_reg_o);
      for (int p = 0; p < NUM_PADS; p++)
      begin
         check_value($sformatf("rst_pad_mux%0d", p), 0, pad_mux_o[p]);
         check_value($sformatf("rst_pad_cfg%0d", p), 6'h3F, pad_cfg_o[p]);
      end
   endtask

   initial
   begin
      word_t rdata;
      int    p;
      void'($urandom(45));
      HRESETn             = 1'b0;
      PADDR               = '0;
      PWDATA              = '0;
      PWRITE              = 1'b0;
      PSEL                = 1'b0;
      PENABLE             = 1'b0;
      fc_fetch_en_valid_i = 1'b0;
      fc_fetch_en_i       = 1'b0;
      soc_jtag_reg_i      = '0;
      bootsel_i           = 1'b0;
      sel_fll_clk_i       = 1'b0;
      jtag_in             = $urandom;
      build_table();
      cycle_limit = 4 * (steps.size() * 2 + RESET_CYCLES + 50);
      repeat (RESET_CYCLES) @(negedge HCLK);
      HRESETn = 1'b1;
      check_reset_ports();
      soc_jtag_reg_i = jtag_in;                       // settles long before readback
      bootsel_i      = 1'b1;
      sel_fll_clk_i  = 1'b1;
      repeat (3) @(negedge HCLK);
      for (int i = 0; i < steps.size(); i++)
      begin
         apb_access(steps[i].wr, steps[i].addr, steps[i].wdata, rdata);
         if (!steps[i].wr)
            check_value(step_name[i], steps[i].exp & steps[i].mask, rdata & steps[i].mask);
      end
      bus_idle();
      for (int k = 0; k < 4; k++)
      begin
         p = sample_pads[k];
         check_value($sformatf("pad_mux%0d", p), fun_words[p / 16][(p % 16) * 2 +: 2],
                     pad_mux_o[p]);
         check_value($sformatf("pad_cfg%0d", p), cfg_words[p / 4][(p % 4) * 8 +: 6],
                     pad_cfg_o[p]);
      end
      check_value("fc_bootaddr_o", fcboot_w, fc_bootaddr_o);
      check_value("cluster_boot_addr_o", {boot1_w, boot0_w}, cluster_boot_addr_o);
      check_value("cluster_ctrl_o", cctrl_w[3:0], cluster_ctrl_o);
      check_value("cluster_irq_o", irq_w[0], cluster_irq_o);
      check_value("soc_jtag_reg_o", jtag_w[7:0], soc_jtag_reg_o);
      @(negedge HCLK);
      fc_fetch_en_valid_i = 1'b1;                     // side-band load of 1
      fc_fetch_en_i       = 1'b1;
      @(negedge HCLK);
      fc_fetch_en_valid_i = 1'b0;
      check_value("fetch_en_sideband", 1, fc_fetchen_o);
      apb_access(1'b1, ADDR_FCFETCH, '0, rdata);
      bus_idle();
      check_value("fetch_en_apb_clear", 0, fc_fetchen_o);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire
